// File: compile.f
+incdir+hdl
hdl/corr_pkg.sv
hdl/corr_sequencer.sv
hdl/accum_ram_sdp.sv
hdl/correlate_cos_sin.sv
hdl/correlator_sdp.sv
hdl/correlator_top.sv
test/correlator_sva.sv
test/correlator_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the correlator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
   --top-module correlator_tb -f compile.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/Vcorrelator_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qx "TEST RESULT: PASS"; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: test/correlator_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "corr_defs.svh"

module correlator_tb;

   import corr_pkg::*;

   // Slot i pairs antenna i with antenna 23-i
   // Slot 11 comes first with b above a
   localparam pair_table_t TB_PAIRS = {
      5'd12, 5'd11, 5'd13, 5'd10, 5'd14, 5'd9,  5'd15, 5'd8,
      5'd16, 5'd7,  5'd17, 5'd6,  5'd18, 5'd5,  5'd19, 5'd4,
      5'd20, 5'd3,  5'd21, 5'd2,  5'd22, 5'd1,  5'd23, 5'd0
   };
   localparam int CLK_PERIOD = 20;
   localparam int PAIR_BITS  = 2 * `CORR_SLOT_BITS;
   localparam int COUNT_MOD  = 1 << `CORR_ACCUM;
   localparam slot_t SLOT_LAST = slot_t'(`CORR_SLOTS - 1);
   // Accepted and busy strobes over all tests
   localparam int N_STROBES = 135;
   localparam int WATCHDOG_CYCLES = N_STROBES * 20 + 500;

   logic clk_x;
   logic reset;
   logic strobe;
   ant_t re;
   ant_t im;
   logic [`CORR_BLOCK_BITS-1:0] block_len;
   logic res_valid;
   slot_t res_slot;
   accum_t res_cos;
   accum_t res_sin;
   logic overflow_cos;
   logic overflow_sin;

   integer seed;
   int errors;
   int checks;
   int test_errors;
   int beats_seen;
   int beats_expected;
   int blk_fill;
   string cur_test;
   bit sticky_cos;
   bit sticky_sin;

   // Accepted samples of the block in progress
   ant_t blk_re [256];
   ant_t blk_im [256];

   // Expected result beats in arrival order
   // Flag expectations once per block
   slot_t exp_slot_q [$];
   accum_t exp_cos_q [$];
   accum_t exp_sin_q [$];
   bit exp_ovf_cos_q [$];
   bit exp_ovf_sin_q [$];

   correlator_top #(
      .PAIRS (TB_PAIRS)
   ) u_correlator_top (
      .clk_x        (clk_x),
      .reset        (reset),
      .strobe       (strobe),
      .re           (re),
      .im           (im),
      .block_len    (block_len),
      .res_valid    (res_valid),
      .res_slot     (res_slot),
      .res_cos      (res_cos),
      .res_sin      (res_sin),
      .overflow_cos (overflow_cos),
      .overflow_sin (overflow_sin)
   );

   always #(CLK_PERIOD / 2) clk_x = ~clk_x;

   // ----------------------------------------------------------------------
   // Reference model
   // ----------------------------------------------------------------------

   // Agreement counts of one slot over the stored block wrapped to the count width
   function automatic void ref_counts(input pair_table_t pairs, input int blen,
                                      input int slot, output accum_t cos_exp,
                                      output accum_t sin_exp, output bit wrap_cos,
                                      output bit wrap_sin);
      int a;
      int b;
      int len;
      int n_cos;
      int n_sin;
      len = (blen == 0) ? 256 : blen;
      a = int'(pairs[slot*PAIR_BITS +: `CORR_SLOT_BITS]);
      b = int'(pairs[slot*PAIR_BITS + `CORR_SLOT_BITS +: `CORR_SLOT_BITS]);
      n_cos = 0;
      n_sin = 0;
      for (int i = 0; i < len; i++) begin
         // Cosine compares real of a with real of b
         if (blk_re[i][a] == blk_re[i][b]) n_cos++;
         // Sine compares real of a with imaginary of b
         if (blk_re[i][a] == blk_im[i][b]) n_sin++;
      end
      cos_exp  = accum_t'(n_cos % COUNT_MOD);
      sin_exp  = accum_t'(n_sin % COUNT_MOD);
      wrap_cos = (n_cos >= COUNT_MOD);
      wrap_sin = (n_sin >= COUNT_MOD);
   endfunction

   // ----------------------------------------------------------------------
   // Compare tasks
   // ----------------------------------------------------------------------

   task automatic check_count(input string what, input accum_t expected, input accum_t actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("Fail %s %s: expected %0d, actual %0d", cur_test, what, expected, actual);
      end
   endtask

   task automatic check_slot(input string what, input slot_t expected, input slot_t actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("Fail %s %s: expected %0d, actual %0d", cur_test, what, expected, actual);
      end
   endtask

   task automatic check_flag(input string what, input bit expected, input bit actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("Fail %s %s: expected %0d, actual %0d", cur_test, what, expected, actual);
      end
   endtask

   // ----------------------------------------------------------------------
   // Stimulus helpers
   // ----------------------------------------------------------------------

   // Queue the 12 expected beats of a finished block
   task automatic push_block(input int blen);
      accum_t c;
      accum_t s;
      bit wc;
      bit ws;
      for (int slot = 0; slot < `CORR_SLOTS; slot++) begin
         ref_counts(TB_PAIRS, blen, slot, c, s, wc, ws);
         exp_slot_q.push_back(slot_t'(slot));
         exp_cos_q.push_back(c);
         exp_sin_q.push_back(s);
         sticky_cos = sticky_cos | wc;
         sticky_sin = sticky_sin | ws;
      end
      exp_ovf_cos_q.push_back(sticky_cos);
      exp_ovf_sin_q.push_back(sticky_sin);
      beats_expected += `CORR_SLOTS;
   endtask

   // One accepted strobe and optionally a lost strobe 5 cycles later
   task automatic send_sample(input ant_t r, input ant_t i, input bit busy);
      int len;
      strobe = 1'b1;
      re = r;
      im = i;
      blk_re[blk_fill] = r;
      blk_im[blk_fill] = i;
      blk_fill++;
      len = (block_len == 0) ? 256 : int'(block_len);
      if (blk_fill == len) begin
         push_block(int'(block_len));
         blk_fill = 0;
      end
      @(posedge clk_x);
      #1;
      strobe = 1'b0;
      // Sequencer is busy until the edge after slot 11
      for (int c = 1; c <= `CORR_SLOTS; c++) begin
         if (busy && c == 5) begin
            strobe = 1'b1;
            re = ant_t'($random(seed));
            im = ant_t'($random(seed));
         end
         if (busy && c == 6) strobe = 1'b0;
         @(posedge clk_x);
         #1;
      end
   endtask

   task automatic apply_reset();
      reset  = 1'b1;
      strobe = 1'b0;
      repeat (16) @(posedge clk_x);
      #1;
      reset = 1'b0;
      sticky_cos = 1'b0;
      sticky_sin = 1'b0;
      blk_fill = 0;
   endtask

   task automatic start_test(input string name, input int blen);
      cur_test = name;
      block_len = blen[`CORR_BLOCK_BITS-1:0];
      beats_seen = 0;
      beats_expected = 0;
      test_errors = errors;
   endtask

   // Wait for outstanding beats and report the test
   task automatic finish_test();
      int n;
      n = 0;
      while (exp_slot_q.size() != 0 && n < 40) begin
         @(posedge clk_x);
         n++;
      end
      // A few idle cycles so stray beats get noticed
      repeat (4) @(posedge clk_x);
      #1;
      if (exp_slot_q.size() != 0) begin
         errors++;
         $display("%s: results of %0d slots never appeared", cur_test, exp_slot_q.size());
         exp_slot_q.delete();
         exp_cos_q.delete();
         exp_sin_q.delete();
         exp_ovf_cos_q.delete();
         exp_ovf_sin_q.delete();
      end
      if (beats_seen != beats_expected) begin
         errors++;
         $display("Fail %s beat count: expected %0d, actual %0d", cur_test, beats_expected,
                  beats_seen);
      end
      $display("%s: %0d result beats, %0d errors", cur_test, beats_seen, errors - test_errors);
   endtask

   // ----------------------------------------------------------------------
   // Result monitor sampling away from the active edge
   // ----------------------------------------------------------------------

   always @(negedge clk_x) begin : monitor
      slot_t es;
      accum_t ec;
      accum_t esn;
      if (res_valid === 1'b1) begin
         beats_seen++;
         if (exp_slot_q.size() == 0) begin
            errors++;
            $display("%s: result beat for slot %0d arrived outside a block end", cur_test,
                     res_slot);
         end else begin
            es  = exp_slot_q.pop_front();
            ec  = exp_cos_q.pop_front();
            esn = exp_sin_q.pop_front();
            check_slot("res_slot", es, res_slot);
            check_count($sformatf("slot %0d cos", es), ec, res_cos);
            check_count($sformatf("slot %0d sin", es), esn, res_sin);
            // Flags settle by the last beat of the burst
            if (es == SLOT_LAST) begin
               check_flag("overflow_cos", exp_ovf_cos_q.pop_front(), overflow_cos);
               check_flag("overflow_sin", exp_ovf_sin_q.pop_front(), overflow_sin);
            end
         end
      end
   end

   // ----------------------------------------------------------------------
   // Watchdog
   // ----------------------------------------------------------------------

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   // ----------------------------------------------------------------------
   // Test sequence
   // ----------------------------------------------------------------------

   initial begin : main
      ant_t r;
      clk_x = 1'b0;
      reset = 1'b1;
      strobe = 1'b0;
      re = '0;
      im = '0;
      block_len = 1;
      seed = 16;
      errors = 0;
      checks = 0;
      cur_test = "reset";
      apply_reset();

      // Every sample is its own block
      start_test("single_sample", 1);
      repeat (12) send_sample(ant_t'($random(seed)), ant_t'($random(seed)), 1'b0);
      finish_test();

      // Sums over 8 samples with each new block starting from zero
      start_test("integration", 8);
      repeat (24) send_sample(ant_t'($random(seed)), ant_t'($random(seed)), 1'b0);
      finish_test();

      // One burst per block and none in between
      start_test("burst_per_block", 4);
      repeat (12) send_sample(ant_t'($random(seed)), ant_t'($random(seed)), 1'b0);
      finish_test();

      // Strobes during a pass are lost
      start_test("busy_strobes", 4);
      repeat (8) send_sample(ant_t'($random(seed)), ant_t'($random(seed)), 1'b1);
      finish_test();

      // All antennas equal so every sample agrees and 70 wraps to 6
      start_test("overflow", 70);
      repeat (70) begin
         r = ($random(seed) & 1) ? '1 : '0;
         send_sample(r, r, 1'b0);
      end
      finish_test();

      // Flags stay up over a later block until reset clears them
      start_test("overflow_sticky", 1);
      send_sample(ant_t'($random(seed)), ant_t'($random(seed)), 1'b0);
      finish_test();
      apply_reset();
      @(negedge clk_x);
      check_flag("overflow_cos after reset", 1'b0, overflow_cos);
      check_flag("overflow_sin after reset", 1'b0, overflow_sin);
      $display("%s: reset clear checked, %0d errors", cur_test, errors - test_errors);

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: test/correlator_sva.sv
`timescale 1ns/100ps
`default_nettype none

`include "corr_defs.svh"

module correlator_sva (
   input logic             clk_x,
   input logic             reset,
   input logic             en,
   input corr_pkg::slot_t  rd,
   input logic             res_valid,
   input corr_pkg::slot_t  res_slot,
   input logic             overflow_cos,
   input logic             overflow_sin
);

   import corr_pkg::*;

   localparam slot_t SLOT_LAST = slot_t'(`CORR_SLOTS - 1);
   localparam slot_t SLOT_STEP = slot_t'(1);

   // ----------------------------------------------------------------------
   // Pass shape, which also spaces accepted strobes
   // ----------------------------------------------------------------------

   a_pass_start: assert property (@(posedge clk_x) disable iff (reset)
      $rose(en) |-> (rd == '0))
      else $error("Pass did not start at slot 0");

   a_rd_step: assert property (@(posedge clk_x) disable iff (reset)
      (en && rd != SLOT_LAST) |=> (en && rd == $past(rd) + SLOT_STEP))
      else $error("Slot address did not step by one during a pass");

   a_pass_end: assert property (@(posedge clk_x) disable iff (reset)
      (en && rd == SLOT_LAST) |=> !en)
      else $error("Pass ran past slot 11");

   // ----------------------------------------------------------------------
   // Result bursts, 12 beats with ascending slots
   // ----------------------------------------------------------------------

   a_burst_start: assert property (@(posedge clk_x) disable iff (reset)
      $rose(res_valid) |-> (res_slot == '0))
      else $error("Result burst did not start at slot 0");

   a_burst_step: assert property (@(posedge clk_x) disable iff (reset)
      (res_valid && res_slot != SLOT_LAST) |=>
         (res_valid && res_slot == $past(res_slot) + SLOT_STEP))
      else $error("Result burst broke off or skipped a slot");

   a_burst_end: assert property (@(posedge clk_x) disable iff (reset)
      (res_valid && res_slot == SLOT_LAST) |=> !res_valid)
      else $error("Result burst longer than 12 beats");

   // Sticky flags
   a_ovf_cos_sticky: assert property (@(posedge clk_x) disable iff (reset)
      overflow_cos |=> overflow_cos)
      else $error("Cosine overflow flag fell without reset");

   a_ovf_sin_sticky: assert property (@(posedge clk_x) disable iff (reset)
      overflow_sin |=> overflow_sin)
      else $error("Sine overflow flag fell without reset");

endmodule

bind correlator_top correlator_sva u_correlator_sva (
   .clk_x        (clk_x),
   .reset        (reset),
   .en           (en),
   .rd           (rd),
   .res_valid    (res_valid),
   .res_slot     (res_slot),
   .overflow_cos (overflow_cos),
   .overflow_sin (overflow_sin)
);

`default_nettype wire

// File: hdl/correlator_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "corr_defs.svh"

module correlator_top #(
   parameter corr_pkg::pair_table_t PAIRS = corr_pkg::DEFAULT_PAIRS
) (
   input  logic                        clk_x,
   input  logic                        reset,
   input  logic                        strobe,
   input  corr_pkg::ant_t              re,
   input  corr_pkg::ant_t              im,
   input  logic [`CORR_BLOCK_BITS-1:0] block_len,
   output logic                        res_valid,
   output corr_pkg::slot_t             res_slot,
   output corr_pkg::accum_t            res_cos,
   output corr_pkg::accum_t            res_sin,
   output logic                        overflow_cos,
   output logic                        overflow_sin
);

   import corr_pkg::*;

   logic en;
   logic sw;
   logic last;
   logic vld;
   slot_t rd;
   ant_t re_hold;
   ant_t im_hold;
   logic [`CORR_RESULT_DELAY-1:0] last_pipe;

   corr_sequencer u_corr_sequencer (
      .clk_x     (clk_x),
      .reset     (reset),
      .strobe    (strobe),
      .re        (re),
      .im        (im),
      .block_len (block_len),
      .en        (en),
      .rd        (rd),
      .sw        (sw),
      .last      (last),
      .re_hold   (re_hold),
      .im_hold   (im_hold)
   );

   correlator_sdp #(
      .PAIRS (PAIRS)
   ) u_correlator_sdp (
      .clk_x        (clk_x),
      .reset        (reset),
      .en           (en),
      .sw           (sw),
      .rd           (rd),
      .re           (re_hold),
      .im           (im_hold),
      .vld          (vld),
      .slot         (res_slot),
      .vis_cos      (res_cos),
      .vis_sin      (res_sin),
      .overflow_cos (overflow_cos),
      .overflow_sin (overflow_sin)
   );

   // ----------------------------------------------------------------------
   // Result qualification
   // ----------------------------------------------------------------------

   // last lines up with the counts coming out of the correlate stage
   always_ff @(posedge clk_x) begin
      if (reset) begin
         last_pipe <= '0;
      end else begin
         last_pipe <= {last_pipe[`CORR_RESULT_DELAY-2:0], last};
      end
   end

   // Only the final sample of a block shows its counts
   assign res_valid = vld & last_pipe[`CORR_RESULT_DELAY-1];

endmodule

`default_nettype wire

// File: hdl/correlator_sdp.sv
`timescale 1ns/100ps
`default_nettype none

`include "corr_defs.svh"

module correlator_sdp #(
   parameter corr_pkg::pair_table_t PAIRS = corr_pkg::DEFAULT_PAIRS
) (
   input  logic               clk_x,
   input  logic               reset,
   input  logic               en,
   input  logic               sw,
   input  corr_pkg::slot_t    rd,
   input  corr_pkg::ant_t     re,
   input  corr_pkg::ant_t     im,
   output logic               vld,
   output corr_pkg::slot_t    slot,
   output corr_pkg::accum_t   vis_cos,
   output corr_pkg::accum_t   vis_sin,
   output logic               overflow_cos,
   output logic               overflow_sin
);

   import corr_pkg::*;

   localparam int PAIR_BITS = 2 * `CORR_SLOT_BITS;

   // Read stage plus one correlate cycle must make up the write-back delay
   if (`CORR_RESULT_DELAY != `CORR_RD_DELAY + 1) begin : g_delay_check
      $error("correlator_sdp: result delay must be read delay plus one");
   end

   logic [PAIR_BITS-1:0] pair;
   logic [`CORR_SLOT_BITS-1:0] a_index;
   logic [`CORR_SLOT_BITS-1:0] b_index;
   logic go;
   logic ar;
   logic br;
   logic bi;
   accum_t rcos;
   accum_t rsin;
   accum_t dcos;
   accum_t dsin;
   slot_t rd_pipe [`CORR_RESULT_DELAY];

   // ----------------------------------------------------------------------
   // Pair lookup and bit selection
   // ----------------------------------------------------------------------

   assign pair    = PAIRS[rd*PAIR_BITS +: PAIR_BITS];
   assign a_index = pair[`CORR_SLOT_BITS-1:0];
   assign b_index = pair[PAIR_BITS-1:`CORR_SLOT_BITS];

   // ----------------------------------------------------------------------
   // Read stage
   // ----------------------------------------------------------------------

   always_ff @(posedge clk_x) begin
      if (reset) begin
         go <= 1'b0;
      end else begin
         go <= en;
      end
   end

   // Bank switch feeds zero, so the block starts fresh
   always_ff @(posedge clk_x) begin
      ar   <= re[a_index];
      br   <= re[b_index];
      bi   <= im[b_index];
      dcos <= sw ? '0 : rcos;
      dsin <= sw ? '0 : rsin;
   end

   // Slot address follows its data down the pipe to the write port
   always_ff @(posedge clk_x) begin
      rd_pipe[0] <= rd;
      for (int i = 1; i < `CORR_RESULT_DELAY; i++) begin
         rd_pipe[i] <= rd_pipe[i-1];
      end
   end

   assign slot = rd_pipe[`CORR_RESULT_DELAY-1];

   // ----------------------------------------------------------------------
   // Correlate stage and accumulator memories
   // ----------------------------------------------------------------------

   correlate_cos_sin u_correlate_cos_sin (
      .clk_x        (clk_x),
      .reset        (reset),
      .en           (go),
      .ar           (ar),
      .br           (br),
      .bi           (bi),
      .dcos         (dcos),
      .dsin         (dsin),
      .valid        (vld),
      .qcos         (vis_cos),
      .qsin         (vis_sin),
      .overflow_cos (overflow_cos),
      .overflow_sin (overflow_sin)
   );

   accum_ram_sdp u_ram_cos (
      .clk_x (clk_x),
      .we    (vld),
      .waddr (slot),
      .wdata (vis_cos),
      .raddr (rd),
      .rdata (rcos)
   );

   accum_ram_sdp u_ram_sin (
      .clk_x (clk_x),
      .we    (vld),
      .waddr (slot),
      .wdata (vis_sin),
      .raddr (rd),
      .rdata (rsin)
   );

endmodule

`default_nettype wire

// File: hdl/correlate_cos_sin.sv
`timescale 1ns/100ps
`default_nettype none

`include "corr_defs.svh"

module correlate_cos_sin (
   input  logic               clk_x,
   input  logic               reset,
   input  logic               en,
   input  logic               ar,
   input  logic               br,
   input  logic               bi,
   input  corr_pkg::accum_t   dcos,
   input  corr_pkg::accum_t   dsin,
   output logic               valid,
   output corr_pkg::accum_t   qcos,
   output corr_pkg::accum_t   qsin,
   output logic               overflow_cos,
   output logic               overflow_sin
);

   import corr_pkg::*;

   localparam logic [`CORR_ACCUM:0] SUM_ZERO = '0;

   logic cos_inc;
   logic sin_inc;
   logic [`CORR_ACCUM:0] cos_sum;
   logic [`CORR_ACCUM:0] sin_sum;

   // ----------------------------------------------------------------------
   // Agreement of sign bits
   // ----------------------------------------------------------------------

   // Real of a against real of b
   assign cos_inc = ~(ar ^ br);

   // Real of a against imaginary of b
   assign sin_inc = ~(ar ^ bi);

   // One extra bit catches the carry out of the all-ones value
   assign cos_sum = {1'b0, dcos} + (SUM_ZERO | cos_inc);
   assign sin_sum = {1'b0, dsin} + (SUM_ZERO | sin_inc);

   // ----------------------------------------------------------------------
   // Result and flag registers
   // ----------------------------------------------------------------------

   always_ff @(posedge clk_x) begin
      if (reset) begin
         valid        <= 1'b0;
         overflow_cos <= 1'b0;
         overflow_sin <= 1'b0;
      end else begin
         valid <= en;
         // Sticky, only reset brings them down again
         if (en && cos_sum[`CORR_ACCUM]) begin
            overflow_cos <= 1'b1;
         end
         if (en && sin_sum[`CORR_ACCUM]) begin
            overflow_sin <= 1'b1;
         end
      end
   end

   // Wrapped counts, written back to RAM with valid
   always_ff @(posedge clk_x) begin
      if (en) begin
         qcos <= cos_sum[`CORR_ACCUM-1:0];
         qsin <= sin_sum[`CORR_ACCUM-1:0];
      end
   end

endmodule

`default_nettype wire

// File: hdl/accum_ram_sdp.sv
`timescale 1ns/100ps
`default_nettype none

`include "corr_defs.svh"

module accum_ram_sdp (
   input  logic               clk_x,
   input  logic               we,
   input  corr_pkg::slot_t    waddr,
   input  corr_pkg::accum_t   wdata,
   input  corr_pkg::slot_t    raddr,
   output corr_pkg::accum_t   rdata
);

   import corr_pkg::*;

   // Full address space, only the first 12 entries carry counts
   localparam int DEPTH = 1 << `CORR_SLOT_BITS;

   // ----------------------------------------------------------------------
   // Distributed RAM, one write port and one read port
   // ----------------------------------------------------------------------

   accum_t mem [DEPTH];

   // Write-back from the correlate stage
   always_ff @(posedge clk_x) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
   end

   // Asynchronous read, registered by the read stage outside
   assign rdata = mem[raddr];

endmodule

`default_nettype wire

// File: hdl/corr_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

`include "corr_defs.svh"

module corr_sequencer (
   input  logic                        clk_x,
   input  logic                        reset,
   input  logic                        strobe,
   input  corr_pkg::ant_t              re,
   input  corr_pkg::ant_t              im,
   input  logic [`CORR_BLOCK_BITS-1:0] block_len,
   output logic                        en,
   output corr_pkg::slot_t             rd,
   output logic                        sw,
   output logic                        last,
   output corr_pkg::ant_t              re_hold,
   output corr_pkg::ant_t              im_hold
);

   import corr_pkg::*;

   localparam slot_t SLOT_LAST = slot_t'(`CORR_SLOTS - 1);
   localparam slot_t SLOT_STEP = slot_t'(1);
   localparam logic [`CORR_BLOCK_BITS-1:0] BLK_ONE = 1;

   seq_state_t state;
   logic [`CORR_BLOCK_BITS-1:0] sample_cnt;
   logic [`CORR_BLOCK_BITS-1:0] last_index;
   logic accept;
   logic pass_done;
   logic is_last;

   // ----------------------------------------------------------------------
   // Strobe qualification
   // ----------------------------------------------------------------------

   // Strobes that land during a pass are simply lost
   assign accept = (state == SEQ_IDLE) && strobe;

   // Index of the final sample; block_len of 0 wraps to 255, i.e. 256 samples
   assign last_index = block_len - BLK_ONE;
   assign is_last    = (sample_cnt == last_index);

   // Slot 11 is the final cycle of the pass
   assign pass_done = (rd == SLOT_LAST);

   // ----------------------------------------------------------------------
   // Pass control
   // ----------------------------------------------------------------------

   always_ff @(posedge clk_x) begin
      if (reset) begin
         state      <= SEQ_IDLE;
         en         <= 1'b0;
         rd         <= '0;
         sw         <= 1'b0;
         last       <= 1'b0;
         sample_cnt <= '0;
      end else begin
         case (state)
            SEQ_IDLE: begin
               if (strobe) begin
                  state <= SEQ_RUN;
                  en    <= 1'b1;
                  rd    <= '0;
                  // First sample of a block clears the accumulators
                  sw    <= (sample_cnt == '0);
                  last  <= is_last;
                  // Sample position within the block
                  if (is_last) begin
                     sample_cnt <= '0;
                  end else begin
                     sample_cnt <= sample_cnt + BLK_ONE;
                  end
               end
            end
            SEQ_RUN: begin
               if (pass_done) begin
                  state <= SEQ_IDLE;
                  en    <= 1'b0;
                  sw    <= 1'b0;
                  last  <= 1'b0;
               end else begin
                  rd <= rd + SLOT_STEP;
               end
            end
            default: begin
               state <= SEQ_IDLE;
               en    <= 1'b0;
            end
         endcase
      end
   end

   // Antenna bits held steady for the whole pass
   always_ff @(posedge clk_x) begin
      if (accept) begin
         re_hold <= re;
         im_hold <= im;
      end
   end

endmodule

`default_nettype wire

// File: hdl/corr_pkg.sv
`default_nettype none

`include "corr_defs.svh"

package corr_pkg;

   // Sequencer waits for a strobe, then runs one pass over all slots
   typedef enum logic {
      SEQ_IDLE,
      SEQ_RUN
   } seq_state_t;

   typedef logic [`CORR_ANTENNAS-1:0] ant_t;
   typedef logic [`CORR_SLOT_BITS-1:0] slot_t;
   typedef logic [`CORR_ACCUM-1:0] accum_t;

   // Slot i sits at bits [10*i +: 10], antenna a low, antenna b high
   typedef logic [2*`CORR_SLOT_BITS*`CORR_SLOTS-1:0] pair_table_t;

   // Default pairing, slot 11 first
   localparam pair_table_t DEFAULT_PAIRS = {
      5'd23, 5'd20, 5'd18, 5'd17, 5'd16, 5'd15, 5'd14, 5'd13,
      5'd12, 5'd11, 5'd10, 5'd9,  5'd8,  5'd7,  5'd6,  5'd5,
      5'd4,  5'd3,  5'd2,  5'd1,  5'd2,  5'd0,  5'd1,  5'd0
   };

endpackage

`default_nettype wire

// File: hdl/corr_defs.svh
`ifndef CORR_DEFS_SVH
`define CORR_DEFS_SVH

// ----------------------------------------------------------------------
// Array size
// ----------------------------------------------------------------------

// One real and one imaginary sign bit per antenna
`define CORR_ANTENNAS 24

// Antenna pairs handled in one pass, one per clock
`define CORR_SLOTS 12

// Slot address, RAM address and antenna index all share this width
`define CORR_SLOT_BITS 5

// ----------------------------------------------------------------------
// Datapath widths and latencies
// ----------------------------------------------------------------------

// Cosine and sine counts, wrap at all-ones
`define CORR_ACCUM 6

// Width of block_len, zero means 256 samples
`define CORR_BLOCK_BITS 8

// Read stage latency, then one more cycle in the correlate stage
`define CORR_RD_DELAY 1
`define CORR_RESULT_DELAY 2

`endif
